// ==== hw/cart_config.svh ====
// Widths, ROM header offsets and default sizes shared by the cartridge loader RTL
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// Host download bus and work-RAM widths
`define CART_ADDR_BITS 25
`define CART_DATA_BITS 16
`define WRAM_ADDR_BITS 17

// Download index reserved for cheat data
`define CODE_INDEX 8'hFF

// Copier header prepended to the ROM image
`define COPIER_HDR 'h200

// Header addresses of the ROM size and RAM size bytes, per layout
`define LOROM_HDR_SIZE 'h7FD6
`define HIROM_HDR_SIZE 'hFFD6
`define EXHIROM_HDR_SIZE 'h40FFD6
`define LOROM_HDR_RAM 'h7FD8
`define HIROM_HDR_RAM 'hFFD8
`define EXHIROM_HDR_RAM 'h40FFD8

// ROM size code when the image carries no size
`define DEFAULT_ROM_SIZE 4'hC

`endif

// ==== hw/cart_pkg.sv ====
// Types shared by the cartridge loader blocks, referenced by scoped name
`default_nettype none

package cart_pkg;

	// ==============================
	// User selections
	// ==============================

	// ROM header interpretation chosen in the menu
	typedef enum logic [2:0] {
		hdr_auto      = 3'd0,
		hdr_no_header = 3'd1,
		hdr_lorom     = 3'd2,
		hdr_hirom     = 3'd3,
		hdr_exhirom   = 3'd4
	} header_mode_e;

	// Power-on work-RAM pattern
	typedef enum logic [1:0] {
		fill_snes2 = 2'd0,
		fill_snes1 = 2'd1,
		fill_p55   = 2'd2,
		fill_pff   = 2'd3
	} fill_mode_e;

	// ==============================
	// Loader results
	// ==============================

	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic        pal;
	} rom_info_t;

	// Fields are big endian as delivered by the host
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

// ==== hw/download_if.sv ====
// Routed download stream from the router to the header parser, cheat assembler and RAM clear
`default_nettype none

`include "cart_config.svh"

interface download_if;

	logic                       cart_active;
	logic                       cart_start;
	logic                       code_active;
	logic                       wr;
	logic [`CART_ADDR_BITS-1:0] addr;
	logic [`CART_DATA_BITS-1:0] data;

	// Router owns every signal
	modport router (
		output cart_active,
		output cart_start,
		output code_active,
		output wr,
		output addr,
		output data
	);

	// Consumers accept every write, no back-pressure
	modport sink (
		input cart_active,
		input cart_start,
		input code_active,
		input wr,
		input addr,
		input data
	);

endinterface

`default_nettype wire

// ==== hw/download_router.sv ====
// Registers the host download stream and splits it into cartridge and cheat traffic
`default_nettype none

`include "cart_config.svh"

module download_router (
	input  wire                       clk_sys,
	input  wire                       RESET,
	input  wire                       ioctl_download,
	input  wire [7:0]                 ioctl_index,
	input  wire                       ioctl_wr,
	input  wire [`CART_ADDR_BITS-1:0] ioctl_addr,
	input  wire [`CART_DATA_BITS-1:0] ioctl_dout,
	download_if.router                dl
);

	logic code_index;
	logic cart_level;
	logic code_level;

	// Index all ones carries cheat codes, anything else is a cartridge
	assign code_index = (ioctl_index == `CODE_INDEX);
	assign cart_level = ioctl_download & ~code_index;
	assign code_level = ioctl_download & code_index;

	// ==============================
	// Control
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl.cart_active <= 1'b0;
			dl.cart_start  <= 1'b0;
			dl.code_active <= 1'b0;
			dl.wr          <= 1'b0;
		end else begin
			dl.cart_active <= cart_level;
			// Registered level is the previous cartridge level here
			dl.cart_start  <= cart_level & ~dl.cart_active;
			dl.code_active <= code_level;
			dl.wr          <= ioctl_wr & ioctl_download;
		end
	end

	// Payload follows the strobe by the same cycle
	always_ff @(posedge clk_sys) begin
		dl.addr <= ioctl_addr;
		dl.data <= ioctl_dout;
	end

endmodule

`default_nettype wire

// ==== hw/rom_header_parser.sv ====
// Reads the ROM header during a cartridge download and derives type, masks and region
`default_nettype none

`include "cart_config.svh"

module rom_header_parser (
	input  wire                     clk_sys,
	input  wire                     RESET,
	download_if.sink                dl,
	input  cart_pkg::header_mode_e  header_mode,
	input  wire [1:0]               region_mode,
	output cart_pkg::rom_info_t     info
);

	logic [7:0]                 rom_type_q;
	logic [3:0]                 rom_size;
	logic [3:0]                 ram_size;
	logic                       rom_region;
	logic                       pal_q;
	logic                       hdr_seen;
	logic                       cart_wr;
	logic                       hdr_fixed;
	logic [`CART_ADDR_BITS-1:0] size_addr;
	logic [`CART_ADDR_BITS-1:0] ram_addr;

	assign cart_wr = dl.cart_active & dl.wr;

	// Header byte locations for the forced layouts, shifted by the copier header
	always_comb begin
		hdr_fixed = 1'b1;
		size_addr = `CART_ADDR_BITS'(`LOROM_HDR_SIZE + `COPIER_HDR);
		ram_addr  = `CART_ADDR_BITS'(`LOROM_HDR_RAM + `COPIER_HDR);
		case (header_mode)
			cart_pkg::hdr_hirom: begin
				size_addr = `CART_ADDR_BITS'(`HIROM_HDR_SIZE + `COPIER_HDR);
				ram_addr  = `CART_ADDR_BITS'(`HIROM_HDR_RAM + `COPIER_HDR);
			end
			cart_pkg::hdr_exhirom: begin
				size_addr = `CART_ADDR_BITS'(`EXHIROM_HDR_SIZE + `COPIER_HDR);
				ram_addr  = `CART_ADDR_BITS'(`EXHIROM_HDR_RAM + `COPIER_HDR);
			end
			cart_pkg::hdr_lorom: ;
			default: hdr_fixed = 1'b0;
		endcase
	end

	// ==============================
	// Header capture
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_type_q <= 8'd0;
			rom_size   <= 4'd0;
			ram_size   <= 4'd0;
			rom_region <= 1'b0;
			hdr_seen   <= 1'b0;
		end else if (cart_wr) begin
			if (dl.addr == '0) begin
				hdr_seen <= 1'b1;
				rom_size <= `DEFAULT_ROM_SIZE;
				ram_size <= 4'd0;
				// Auto mode: loader packs the sizes into the first word
				if (header_mode == cart_pkg::hdr_auto && dl.data[7:0] != 8'd0) begin
					{ram_size, rom_size} <= dl.data[7:0];
				end
				case (header_mode)
					cart_pkg::hdr_no_header,
					cart_pkg::hdr_lorom:   rom_type_q <= 8'd0;
					cart_pkg::hdr_hirom:   rom_type_q <= 8'd1;
					cart_pkg::hdr_exhirom: rom_type_q <= 8'd2;
					default:               rom_type_q <= dl.data[15:8];
				endcase
			end
			if (dl.addr == `CART_ADDR_BITS'(2)) begin
				rom_region <= dl.data[8];
			end
			if (hdr_fixed && dl.addr == size_addr) begin
				rom_size <= dl.data[11:8];
			end
			if (hdr_fixed && dl.addr == ram_addr) begin
				ram_size <= dl.data[3:0];
			end
		end
	end

	// Region only updates between downloads
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			pal_q <= 1'b0;
		end else if (!dl.cart_active) begin
			pal_q <= (region_mode == 2'd0) ? rom_region : region_mode[1];
		end
	end

	// Masks are zero until a cartridge has been seen
	always_comb begin
		info.rom_type = rom_type_q;
		info.pal      = pal_q;
		info.rom_mask = 24'd0;
		info.ram_mask = 24'd0;
		if (hdr_seen) begin
			info.rom_mask = (24'd1024 << rom_size) - 24'd1;
			if (ram_size != 4'd0) begin
				info.ram_mask = (24'd1024 << ram_size) - 24'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/cheat_code_assembler.sv ====
// Collects eight cheat download words into one code and pulses when it is complete
`default_nettype none

module cheat_code_assembler (
	input  wire                 clk_sys,
	input  wire                 RESET,
	download_if.sink            dl,
	output cart_pkg::cheat_code_t code,
	output logic                cheat_valid
);

	cart_pkg::cheat_code_t stage;
	logic                  code_wr;

	assign code_wr = dl.code_active & dl.wr;

	// ==============================
	// Word collection
	// ==============================

	// Offsets 0..12 build up in the staging copy
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.addr[3:0])
				4'd0:  stage.flags[15:0]    <= dl.data;
				4'd2:  stage.flags[31:16]   <= dl.data;
				4'd4:  stage.address[15:0]  <= dl.data;
				4'd6:  stage.address[31:16] <= dl.data;
				4'd8:  stage.compare[15:0]  <= dl.data;
				4'd10: stage.compare[31:16] <= dl.data;
				4'd12: stage.replace[15:0]  <= dl.data;
				default: ;
			endcase
		end
	end

	// Last word commits the whole code at once
	always_ff @(posedge clk_sys) begin
		if (code_wr && dl.addr[3:0] == 4'd14) begin
			code                <= stage;
			code.replace[31:16] <= dl.data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= code_wr && dl.addr[3:0] == 4'd14;
		end
	end

endmodule

`default_nettype wire

// ==== hw/wram_clear_engine.sv ====
// Sweeps every work-RAM address with the power-on fill pattern after a cartridge download starts
`default_nettype none

`include "cart_config.svh"

module wram_clear_engine (
	input  wire                       clk_sys,
	input  wire                       RESET,
	download_if.sink                  dl,
	input  cart_pkg::fill_mode_e      fill_mode,
	output logic [`WRAM_ADDR_BITS-1:0] fill_addr,
	output logic [7:0]                fill_data,
	output logic                      fill_we,
	output logic                      clearing
);

	// ==============================
	// Address sweep
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else if (dl.cart_start) begin
			// A new download restarts the sweep from zero
			clearing  <= 1'b1;
			fill_addr <= '0;
		end else if (clearing) begin
			fill_addr <= fill_addr + 1'b1;
			if (&fill_addr) begin
				clearing <= 1'b0;
			end
		end else begin
			fill_addr <= '0;
		end
	end

	assign fill_we = clearing;

	// Patterns mimic what different console revisions power up with
	always_comb begin
		case (fill_mode)
			cart_pkg::fill_snes2: begin
				fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			end
			cart_pkg::fill_snes1: begin
				fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			end
			cart_pkg::fill_p55: fill_data = 8'h55;
			default:            fill_data = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/cart_loader_top.sv ====
// Cartridge loader top level joining the download router to its three consumers
`default_nettype none

`include "cart_config.svh"

module cart_loader_top (
	input  wire                        clk_sys,
	input  wire                        RESET,
	input  wire                        ioctl_download,
	input  wire [7:0]                  ioctl_index,
	input  wire                        ioctl_wr,
	input  wire [`CART_ADDR_BITS-1:0]  ioctl_addr,
	input  wire [`CART_DATA_BITS-1:0]  ioctl_dout,
	input  cart_pkg::header_mode_e     header_mode,
	input  wire [1:0]                  region_mode,
	input  cart_pkg::fill_mode_e       fill_mode,
	output wire [7:0]                  rom_type,
	output wire [23:0]                 rom_mask,
	output wire [23:0]                 ram_mask,
	output wire                        pal,
	output wire [127:0]                cheat_code,
	output wire                        cheat_valid,
	output wire [`WRAM_ADDR_BITS-1:0]  fill_addr,
	output wire [7:0]                  fill_data,
	output wire                        fill_we,
	output wire                        clearing
);

	cart_pkg::rom_info_t   info;
	cart_pkg::cheat_code_t code;

	download_if dl_bus ();

	download_router u_download_router (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.dl             (dl_bus.router)
	);

	rom_header_parser u_rom_header_parser (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dl          (dl_bus.sink),
		.header_mode (header_mode),
		.region_mode (region_mode),
		.info        (info)
	);

	cheat_code_assembler u_cheat_code_assembler (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dl          (dl_bus.sink),
		.code        (code),
		.cheat_valid (cheat_valid)
	);

	wram_clear_engine u_wram_clear_engine (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dl        (dl_bus.sink),
		.fill_mode (fill_mode),
		.fill_addr (fill_addr),
		.fill_data (fill_data),
		.fill_we   (fill_we),
		.clearing  (clearing)
	);

	// Flatten the results onto plain ports
	assign rom_type   = info.rom_type;
	assign rom_mask   = info.rom_mask;
	assign ram_mask   = info.ram_mask;
	assign pal        = info.pal;
	assign cheat_code = code;

endmodule

`default_nettype wire

// ==== testbench/tb_cart_checks.sv ====
// Reference model and assertions for the cartridge loader, instantiated beside the DUT
`default_nettype none

`include "cart_config.svh"

module tb_cart_checks (
	input  wire                        clk_sys,
	input  wire                        RESET,
	input  wire                        ioctl_download,
	input  wire [7:0]                  ioctl_index,
	input  wire                        ioctl_wr,
	input  wire [`CART_ADDR_BITS-1:0]  ioctl_addr,
	input  wire [`CART_DATA_BITS-1:0]  ioctl_dout,
	input  cart_pkg::header_mode_e     header_mode,
	input  wire [1:0]                  region_mode,
	input  cart_pkg::fill_mode_e       fill_mode,
	input  wire [7:0]                  rom_type,
	input  wire [23:0]                 rom_mask,
	input  wire [23:0]                 ram_mask,
	input  wire                        pal,
	input  wire [127:0]                cheat_code,
	input  wire                        cheat_valid,
	input  wire [`WRAM_ADDR_BITS-1:0]  fill_addr,
	input  wire [7:0]                  fill_data,
	input  wire                        fill_we,
	input  wire                        clearing,
	output int                         error_count,
	output int                         check_count,
	output int                         clears_done,
	output int                         codes_seen
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0]                 exp_type;
	logic [3:0]                 exp_rom_size;
	logic [3:0]                 exp_ram_size;
	logic                       exp_region;
	logic                       exp_seen;
	logic [127:0]               exp_code;
	logic [127:0]               code_snap;
	logic [1:0]                 valid_pipe;
	logic                       cart_prev;
	logic                       start_seen;
	logic                       exp_clearing;
	logic [`WRAM_ADDR_BITS-1:0] exp_addr;
	logic                       dl_prev;
	logic                       rst_prev;
	int                         settle;

	initial begin
		error_count = 0;
		check_count = 0;
		clears_done = 0;
		codes_seen  = 0;
		rst_prev    = 1'b0;
	end

	// ==============================
	// Helpers
	// ==============================

	task automatic expect_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		check_count++;
		assert (got === exp) else begin
			error_count++;
			$display("error %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	// Size code n means 1 KiB << n of address space
	function automatic logic [23:0] size_mask(input logic [3:0] size);
		return (24'd1024 << size) - 24'd1;
	endfunction

	function automatic logic [7:0] pattern(input cart_pkg::fill_mode_e mode,
			input logic [`WRAM_ADDR_BITS-1:0] a);
		case (mode)
			cart_pkg::fill_snes2: return (a[8] != a[2]) ? 8'h66 : 8'h99;
			cart_pkg::fill_snes1: return (a[9] != a[0]) ? 8'hFF : 8'h00;
			cart_pkg::fill_p55:   return 8'h55;
			default:              return 8'hFF;
		endcase
	endfunction

	// Image address of a header byte, copier header included
	function automatic logic [`CART_ADDR_BITS-1:0] layout_addr(
			input cart_pkg::header_mode_e mode, input bit ram);
		logic [`CART_ADDR_BITS-1:0] base;
		case (mode)
			cart_pkg::hdr_hirom:   base = ram ? `HIROM_HDR_RAM : `HIROM_HDR_SIZE;
			cart_pkg::hdr_exhirom: base = ram ? `EXHIROM_HDR_RAM : `EXHIROM_HDR_SIZE;
			default:               base = ram ? `LOROM_HDR_RAM : `LOROM_HDR_SIZE;
		endcase
		return base + `COPIER_HDR;
	endfunction

	// ==============================
	// Model and checks
	// ==============================

	always @(posedge clk_sys) begin
		logic cart_level;
		logic cart_wr;
		logic code_wr;
		logic fixed;
		cart_level = ioctl_download && ioctl_index != `CODE_INDEX;
		cart_wr    = cart_level && ioctl_wr;
		code_wr    = ioctl_download && ioctl_wr && ioctl_index == `CODE_INDEX;
		fixed      = header_mode inside {cart_pkg::hdr_lorom, cart_pkg::hdr_hirom,
			cart_pkg::hdr_exhirom};
		if (RESET) begin
			if (rst_prev) begin
				expect_value("cheat_valid", cheat_valid, 0);
				expect_value("fill_we", fill_we, 0);
				expect_value("clearing", clearing, 0);
			end
			exp_type     = 8'd0;
			exp_rom_size = 4'd0;
			exp_ram_size = 4'd0;
			exp_region   = 1'b0;
			exp_seen     = 1'b0;
			valid_pipe   = 2'b00;
			cart_prev    = 1'b0;
			start_seen   = 1'b0;
			exp_clearing = 1'b0;
			exp_addr     = '0;
			dl_prev      = 1'b0;
			settle       = 0;
		end else begin
			// First cycle out of reset shows the cleared results
			if (rst_prev) begin
				expect_value("rom_type", rom_type, 0);
				expect_value("rom_mask", rom_mask, 0);
				expect_value("ram_mask", ram_mask, 0);
				expect_value("pal", pal, 0);
			end
			expect_value("cheat_valid", cheat_valid, valid_pipe[1]);
			expect_value("clearing", clearing, exp_clearing);
			expect_value("fill_we", fill_we, exp_clearing);
			if (exp_clearing) begin
				expect_value("fill_addr", fill_addr, exp_addr);
				expect_value("fill_data", fill_data, pattern(fill_mode, exp_addr));
			end
			if (cheat_valid) begin
				codes_seen++;
				expect_value("cheat_code", cheat_code, code_snap);
			end
			if (settle == 1) begin
				expect_value("rom_type", rom_type, exp_type);
				expect_value("rom_mask", rom_mask, exp_seen ? size_mask(exp_rom_size) : 0);
				expect_value("ram_mask", ram_mask,
					(exp_seen && exp_ram_size != 0) ? size_mask(exp_ram_size) : 0);
				expect_value("pal", pal, (region_mode == 2'd0) ? exp_region : region_mode[1]);
				if (codes_seen > 0) begin
					expect_value("cheat_code", cheat_code, code_snap);
				end
			end

			// Sweep starts two cycles after the cartridge level rises
			if (start_seen) begin
				exp_clearing = 1'b1;
				exp_addr     = '0;
			end else if (exp_clearing) begin
				if (&exp_addr) begin
					exp_clearing = 1'b0;
					clears_done++;
				end
				exp_addr = exp_addr + 1'b1;
			end
			start_seen = cart_level && !cart_prev;
			cart_prev  = cart_level;

			valid_pipe = {valid_pipe[0], 1'b0};
			if (code_wr && !ioctl_addr[0]) begin
				// Offset bits 3:2 pick the field from the top, bit 1 the half
				exp_code[(3 - ioctl_addr[3:2]) * 32 + ioctl_addr[1] * 16 +: 16] = ioctl_dout;
				if (ioctl_addr[3:0] == 4'd14) begin
					code_snap     = exp_code;
					valid_pipe[0] = 1'b1;
				end
			end

			if (cart_wr) begin
				if (ioctl_addr == '0) begin
					exp_seen     = 1'b1;
					exp_rom_size = `DEFAULT_ROM_SIZE;
					exp_ram_size = 4'd0;
					if (header_mode == cart_pkg::hdr_auto && ioctl_dout[7:0] != 8'd0) begin
						exp_ram_size = ioctl_dout[7:4];
						exp_rom_size = ioctl_dout[3:0];
					end
					case (header_mode)
						cart_pkg::hdr_auto:    exp_type = ioctl_dout[15:8];
						cart_pkg::hdr_hirom:   exp_type = 8'd1;
						cart_pkg::hdr_exhirom: exp_type = 8'd2;
						default:               exp_type = 8'd0;
					endcase
				end
				if (ioctl_addr == 2) begin
					exp_region = ioctl_dout[8];
				end
				if (fixed && ioctl_addr == layout_addr(header_mode, 1'b0)) begin
					exp_rom_size = ioctl_dout[11:8];
				end
				if (fixed && ioctl_addr == layout_addr(header_mode, 1'b1)) begin
					exp_ram_size = ioctl_dout[3:0];
				end
			end

			// Results are compared a few cycles after any download ends
			if (dl_prev && !ioctl_download) begin
				settle = 4;
			end else if (settle > 0) begin
				settle--;
			end
			dl_prev = ioctl_download;
		end
		rst_prev = RESET;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_cart_loader.sv ====
// Testbench top for the cartridge loader that runs the download sequence and reports the verdict
`default_nettype none

`include "cart_config.svh"

module tb_cart_loader;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 10;
	// Four full work-RAM sweeps plus margin for reset and downloads
	localparam int WATCHDOG_CYCLES = 4 * (1 << `WRAM_ADDR_BITS) + 5000;

	logic                       clk_sys;
	logic                       RESET;
	logic                       ioctl_download;
	logic [7:0]                 ioctl_index;
	logic                       ioctl_wr;
	logic [`CART_ADDR_BITS-1:0] ioctl_addr;
	logic [`CART_DATA_BITS-1:0] ioctl_dout;
	cart_pkg::header_mode_e     header_mode;
	logic [1:0]                 region_mode;
	cart_pkg::fill_mode_e       fill_mode;
	wire  [7:0]                 rom_type;
	wire  [23:0]                rom_mask;
	wire  [23:0]                ram_mask;
	wire                        pal;
	wire  [127:0]               cheat_code;
	wire                        cheat_valid;
	wire  [`WRAM_ADDR_BITS-1:0] fill_addr;
	wire  [7:0]                 fill_data;
	wire                        fill_we;
	wire                        clearing;
	int                         error_count;
	int                         check_count;
	int                         clears_done;
	int                         codes_seen;
	logic [1:0]                 fill_next;

	cart_loader_top u_cart_loader_top (.*);

	tb_cart_checks u_cart_checks (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ==============================
	// Stimulus tasks
	// ==============================

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic host_write(input logic [`CART_ADDR_BITS-1:0] addr,
			input logic [`CART_DATA_BITS-1:0] data);
		ioctl_wr   = 1'b1;
		ioctl_addr = addr;
		ioctl_dout = data;
		next_cycle();
		ioctl_wr = 1'b0;
		next_cycle();
	endtask

	task automatic cart_download(input cart_pkg::header_mode_e mode, input logic [1:0] region,
			input logic [`CART_ADDR_BITS-1:0] size_addr,
			input logic [`CART_ADDR_BITS-1:0] ram_addr, input bit ram_none);
		logic [15:0] word0;
		logic [15:0] ram_word;
		logic [15:0] region_word;
		word0      = 16'($urandom);
		// Auto mode only takes sizes from a nonzero low byte
		word0[7:0] = 8'($urandom_range(255, 1));
		ram_word   = 16'($urandom);
		if (ram_none) begin
			ram_word[3:0] = 4'd0;
		end else begin
			ram_word[3:0] = 4'($urandom_range(15, 1));
		end
		region_word    = 16'($urandom);
		// Pick a region bit that a mixup of the region source would reveal
		region_word[8] = (region == 2'd0) ? ~pal : ~region[1];
		header_mode    = mode;
		region_mode    = region;
		// Consecutive downloads step through every fill pattern
		fill_mode      = cart_pkg::fill_mode_e'(fill_next);
		fill_next      = fill_next + 2'd1;
		ioctl_index    = 8'($urandom_range(254, 0));
		ioctl_download = 1'b1;
		next_cycle();
		host_write('0, word0);
		host_write(2, region_word);
		host_write(size_addr, 16'($urandom));
		host_write(ram_addr, ram_word);
		ioctl_download = 1'b0;
		// The sweep outlasts the short header download
		while (!clearing) next_cycle();
		while (clearing) next_cycle();
		repeat (4) next_cycle();
	endtask

	task automatic cheat_download();
		ioctl_index    = `CODE_INDEX;
		ioctl_download = 1'b1;
		next_cycle();
		for (int off = 0; off < 16; off += 2) begin
			host_write(`CART_ADDR_BITS'(off), 16'($urandom));
		end
		ioctl_download = 1'b0;
		while (!cheat_valid) next_cycle();
		repeat (8) next_cycle();
	endtask

	task automatic finish_run(input bit failed);
		$display("checks %0d, errors %0d, clears %0d, cheat codes %0d",
			check_count, error_count, clears_done, codes_seen);
		if (!failed && error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		bit short_run;
		void'($urandom(32'h4267));
		fill_next      = 2'($urandom_range(3, 0));
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		header_mode    = cart_pkg::hdr_auto;
		region_mode    = 2'd0;
		fill_mode      = cart_pkg::fill_snes2;
		repeat (10) @(posedge clk_sys);
		#1;
		RESET = 1'b0;
		next_cycle();
		cart_download(cart_pkg::hdr_auto, 2'd0, `LOROM_HDR_SIZE + `COPIER_HDR,
			`LOROM_HDR_RAM + `COPIER_HDR, 1'b0);
		cart_download(cart_pkg::hdr_lorom, 2'd1, `LOROM_HDR_SIZE + `COPIER_HDR,
			`LOROM_HDR_RAM + `COPIER_HDR, 1'b0);
		cart_download(cart_pkg::hdr_hirom, 2'd2, `HIROM_HDR_SIZE + `COPIER_HDR,
			`HIROM_HDR_RAM + `COPIER_HDR, 1'b1);
		cart_download(cart_pkg::hdr_exhirom, 2'd0, `EXHIROM_HDR_SIZE + `COPIER_HDR,
			`EXHIROM_HDR_RAM + `COPIER_HDR, 1'b0);
		cheat_download();
		short_run = (clears_done != 4) || (codes_seen != 1);
		if (short_run) begin
			$display("sequence incomplete: expected 4 finished clears and 1 cheat code");
		end
		finish_run(short_run);
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("watchdog expired before the download sequence finished");
		finish_run(1'b1);
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/cart_pkg.sv
hw/download_if.sv
hw/download_router.sv
hw/rom_header_parser.sv
hw/cheat_code_assembler.sv
hw/wram_clear_engine.sv
hw/cart_loader_top.sv
testbench/tb_cart_checks.sv
testbench/tb_cart_loader.sv
